/* bench/fm_spy_stim.txt */
# M ch data vld = monitor word, I n = idle cycles, G = random idle gap
# W addr data err = APB write with expected pslverr, R addr data = APB read with expected prdata
R C0 0
R C4 0
R 00 0
M 0 1111 1
G
M 1 AAAA0001 1
G
M 0 2222 1
M 0 DEAD 0
G
M 1 AAAA0002 1
M 0 F333 1
I 2
R 40 1111
R 44 2222
R 48 F333
R 80 AAAA0001
R 84 AAAA0002
R C0 3
R C4 2
M 1 B0000000 1
M 1 B0000001 1
M 1 B0000002 1
M 1 B0000003 1
M 1 B0000004 1
M 1 B0000005 1
M 1 B0000006 1
M 1 B0000007 1
M 1 B0000008 1
M 1 B0000009 1
M 1 B000000A 1
M 1 B000000B 1
M 1 B000000C 1
M 1 B000000D 1
M 1 B000000E 1
I 2
R 80 B000000E
R 84 AAAA0002
R 88 B0000000
R C4 101
R C0 3
W 00 1 0
R 00 1
M 0 4444 1
M 1 C0000001 1
I 2
R C0 3
R C4 102
R 84 C0000001
W 00 0 0
R 00 0
M 0 5555 1
I 2
R 4C 5555
R C0 4
W 44 12345678 1
R 44 2222
W 84 0 1
R 84 C0000001
W C4 FFFF 1
R C4 102
R 00 0

/* files.f */
design/fm_spy_pkg.sv
design/fm_capture.sv
design/fm_spy_mem.sv
design/fm_apb_spy.sv
design/fm_spy_top.sv
bench/tb_clock_gen.sv
bench/tb_fm_spy.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_fm_spy
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_fm_spy.sv */
`timescale 1ns/10ps

module tb_fm_spy;

   import fm_spy_pkg::*;

   localparam int    ready_timeout = 20;
   localparam int    reset_timeout = 50;
   localparam string stim_path     = "bench/fm_spy_stim.txt";

   logic        spy_clock;
   logic        axi_reset;
   mon_narrow_t mon0;
   mon_wide_t   mon1;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;

   tb_clock_gen #(.RESET_CYCLES(5)) u_clk (
      .spy_clock_o (spy_clock),
      .axi_reset_o (axi_reset)
   );

   fm_spy_top #(.SPY_DEPTH(spy_depth_default)) DUT (
      .spy_clock (spy_clock),
      .axi_reset (axi_reset),
      .mon0_i    (mon0),
      .mon1_i    (mon1),
      .apb_i     (apb_req),
      .apb_o     (apb_rsp)
   );

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, expected);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "run stopped");
   endtask

   // inputs change 1 ns after the edge; monitor words last one cycle.
   task automatic next_cycle();
      @(posedge spy_clock);
      #1;
      mon0.vld = 1'b0;
      mon1.vld = 1'b0;
   endtask

   task automatic drive_mon(input logic ch, input logic [31:0] data, input logic vld);
      next_cycle();
      if (ch == 1'b0)
      begin
         mon0.data = data[15:0];
         mon0.vld  = vld;
      end
      else
      begin
         mon1.data = data;
         mon1.vld  = vld;
      end
   endtask

   task automatic apb_transfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      int waited;
      next_cycle();
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      next_cycle();
      apb_req.penable = 1'b1;
      waited = 0;
      while (apb_rsp.pready !== 1'b1)
      begin
         if (waited == ready_timeout)
            stop_run("APB slave never raised pready");
         next_cycle();
         waited++;
      end
      // exactly one wait state per transfer.
      compare_value("apb wait states", 32'(waited), 32'd1);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      next_cycle();
      apb_req = '0;
   endtask

   initial
   begin
      int          fd;
      int          waited;
      int          gap;
      string       line;
      byte         cmd;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] rdata;
      logic        err;

      mon0    = '0;
      mon1    = '0;
      apb_req = '0;
      void'($urandom(60));

      // reset is high by the first edge.
      waited = 0;
      @(posedge spy_clock);
      while (axi_reset !== 1'b0)
      begin
         if (waited == reset_timeout)
            stop_run("reset was never released");
         @(posedge spy_clock);
         waited++;
      end

      fd = $fopen(stim_path, "r");
      if (fd == 0)
         stop_run("could not open the stim file");

      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         cmd = line.getc(0);
         f1  = '0;
         f2  = '0;
         f3  = '0;
         void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", f1, f2, f3));
         case (cmd)
            "M": drive_mon(f1[0], f2, f3[0]);
            "I": repeat (f1) next_cycle();
            "G":
            begin
               gap = $urandom % 4;
               repeat (gap) next_cycle();
            end
            "W":
            begin
               apb_transfer(1'b1, f1[7:0], f2, rdata, err);
               compare_value($sformatf("pslverr on write %02h", f1[7:0]), 32'(err), f3);
            end
            "R":
            begin
               apb_transfer(1'b0, f1[7:0], '0, rdata, err);
               compare_value($sformatf("pslverr on read %02h", f1[7:0]), 32'(err), 32'd0);
               compare_value($sformatf("prdata at %02h", f1[7:0]), rdata, f2);
            end
            default: stop_run("unknown command in the stim file");
         endcase
      end
      $fclose(fd);

      $display("Test completed successfully");
      $finish;
   end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int RESET_CYCLES = 5
)(
   output logic spy_clock_o,
   output logic axi_reset_o
);

   // 10 ns period.
   initial
   begin
      spy_clock_o = 1'b0;
      forever #5 spy_clock_o = ~spy_clock_o;
   end

   // reset drops just after the last reset edge.
   initial
   begin
      axi_reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge spy_clock_o);
      #1;
      axi_reset_o = 1'b0;
   end

endmodule

/* design/fm_spy_top.sv */
`timescale 1ns/10ps

module fm_spy_top #(
   parameter int SPY_DEPTH = fm_spy_pkg::spy_depth_default
)(
   input  logic                    spy_clock,
   input  logic                    axi_reset,
   input  fm_spy_pkg::mon_narrow_t mon0_i,
   input  fm_spy_pkg::mon_wide_t   mon1_i,
   input  fm_spy_pkg::apb_req_t    apb_i,
   output fm_spy_pkg::apb_rsp_t    apb_o
);

   import fm_spy_pkg::*;

   localparam int addr_w = $clog2(SPY_DEPTH);

   logic [1:0]        freeze;
   logic              rd_en;
   logic [addr_w-1:0] rd_addr;

   logic              wr_en0;
   logic [addr_w-1:0] wr_addr0;
   mon_narrow_t       wr_data0;
   mon_narrow_t       rd_data0;
   logic [addr_w-1:0] wr_ptr0;
   logic              wrapped0;

   logic              wr_en1;
   logic [addr_w-1:0] wr_addr1;
   mon_wide_t         wr_data1;
   mon_wide_t         rd_data1;
   logic [addr_w-1:0] wr_ptr1;
   logic              wrapped1;

   // channel 0, narrow.
   fm_capture #(.payload_t(mon_narrow_t), .SPY_DEPTH(SPY_DEPTH)) u_cap0 (
      .spy_clock (spy_clock),
      .axi_reset (axi_reset),
      .mon_i     (mon0_i),
      .freeze_i  (freeze[0]),
      .wr_en_o   (wr_en0),
      .wr_addr_o (wr_addr0),
      .wr_data_o (wr_data0),
      .wr_ptr_o  (wr_ptr0),
      .wrapped_o (wrapped0)
   );

   fm_spy_mem #(.payload_t(mon_narrow_t), .SPY_DEPTH(SPY_DEPTH)) u_mem0 (
      .spy_clock (spy_clock),
      .wr_en_i   (wr_en0),
      .wr_addr_i (wr_addr0),
      .wr_data_i (wr_data0),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data0)
   );

   // channel 1, wide.
   fm_capture #(.payload_t(mon_wide_t), .SPY_DEPTH(SPY_DEPTH)) u_cap1 (
      .spy_clock (spy_clock),
      .axi_reset (axi_reset),
      .mon_i     (mon1_i),
      .freeze_i  (freeze[1]),
      .wr_en_o   (wr_en1),
      .wr_addr_o (wr_addr1),
      .wr_data_o (wr_data1),
      .wr_ptr_o  (wr_ptr1),
      .wrapped_o (wrapped1)
   );

   fm_spy_mem #(.payload_t(mon_wide_t), .SPY_DEPTH(SPY_DEPTH)) u_mem1 (
      .spy_clock (spy_clock),
      .wr_en_i   (wr_en1),
      .wr_addr_i (wr_addr1),
      .wr_data_i (wr_data1),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data1)
   );

   fm_apb_spy #(.SPY_DEPTH(SPY_DEPTH)) u_apb (
      .spy_clock  (spy_clock),
      .axi_reset  (axi_reset),
      .apb_i      (apb_i),
      .apb_o      (apb_o),
      .freeze_o   (freeze),
      .rd_en_o    (rd_en),
      .rd_addr_o  (rd_addr),
      .rd_data0_i (rd_data0),
      .rd_data1_i (rd_data1),
      .wr_ptr0_i  (wr_ptr0),
      .wr_ptr1_i  (wr_ptr1),
      .wrapped0_i (wrapped0),
      .wrapped1_i (wrapped1)
   );

endmodule

/* design/fm_apb_spy.sv */
`timescale 1ns/10ps

module fm_apb_spy #(
   parameter int SPY_DEPTH = fm_spy_pkg::spy_depth_default
)(
   input  logic                         spy_clock,
   input  logic                         axi_reset,
   input  fm_spy_pkg::apb_req_t         apb_i,
   output fm_spy_pkg::apb_rsp_t         apb_o,
   output logic [1:0]                   freeze_o,
   output logic                         rd_en_o,
   output logic [$clog2(SPY_DEPTH)-1:0] rd_addr_o,
   input  fm_spy_pkg::mon_narrow_t      rd_data0_i,
   input  fm_spy_pkg::mon_wide_t        rd_data1_i,
   input  logic [$clog2(SPY_DEPTH)-1:0] wr_ptr0_i,
   input  logic [$clog2(SPY_DEPTH)-1:0] wr_ptr1_i,
   input  logic                         wrapped0_i,
   input  logic                         wrapped1_i
);

   import fm_spy_pkg::*;

   localparam int addr_w = $clog2(SPY_DEPTH);

   logic              setup;
   logic              access1;
   logic              ready_q;
   logic              err_q;
   region_e           region_q;
   logic [apb_dw-1:0] ctrl_word;
   logic [apb_dw-1:0] meta_word;
   logic [apb_dw-1:0] rd_word;

   assign setup   = apb_i.psel & ~apb_i.penable;
   // first access cycle is the wait state.
   assign access1 = apb_i.psel & apb_i.penable & ~ready_q;

   // region is decoded once, in the setup cycle.
   always_ff @(posedge spy_clock)
   begin
      if (setup)
      begin
         region_q <= region_e'(apb_i.paddr[7:6]);
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (axi_reset)
      begin
         ready_q  <= 1'b0;
         err_q    <= 1'b0;
         freeze_o <= 2'b00;
      end
      else if (ready_q)
      begin
         ready_q <= 1'b0;
         err_q   <= 1'b0;
         if (apb_i.pwrite && region_q == ctrl && apb_i.paddr[5:2] == 4'd0)
         begin
            freeze_o <= apb_i.pwdata[1:0];
         end
      end
      else if (access1)
      begin
         ready_q <= 1'b1;
         // only the ctrl region accepts writes.
         err_q   <= apb_i.pwrite & (region_q != ctrl);
      end
   end

   // one read strobe serves both memories.
   assign rd_en_o   = access1 & ~apb_i.pwrite & (region_q == data0 || region_q == data1);
   assign rd_addr_o = apb_i.paddr[2 +: addr_w];

   assign ctrl_word = (apb_i.paddr[5:2] == 4'd0) ? apb_dw'(freeze_o) : '0;

   // paddr[2] picks the channel.
   always_comb
   begin
      meta_word = '0;
      if (apb_i.paddr[2])
      begin
         meta_word[addr_w-1:0] = wr_ptr1_i;
         meta_word[8]          = wrapped1_i;
      end
      else
      begin
         meta_word[addr_w-1:0] = wr_ptr0_i;
         meta_word[8]          = wrapped0_i;
      end
   end

   always_comb
   begin
      case (region_q)
         ctrl:    rd_word = ctrl_word;
         data0:   rd_word = apb_dw'(rd_data0_i.data);
         data1:   rd_word = apb_dw'(rd_data1_i.data);
         default: rd_word = meta_word;
      endcase
   end

   assign apb_o.prdata  = (ready_q && !apb_i.pwrite) ? rd_word : '0;
   assign apb_o.pready  = ready_q;
   assign apb_o.pslverr = err_q;

endmodule

/* design/fm_spy_mem.sv */
`timescale 1ns/10ps

module fm_spy_mem #(
   parameter type payload_t = fm_spy_pkg::mon_narrow_t,
   parameter int  SPY_DEPTH = fm_spy_pkg::spy_depth_default
)(
   input  logic                         spy_clock,
   input  logic                         wr_en_i,
   input  logic [$clog2(SPY_DEPTH)-1:0] wr_addr_i,
   input  payload_t                     wr_data_i,
   input  logic                         rd_en_i,
   input  logic [$clog2(SPY_DEPTH)-1:0] rd_addr_i,
   output payload_t                     rd_data_o
);

   payload_t mem [SPY_DEPTH];

   // capture side write port.
   always_ff @(posedge spy_clock)
   begin
      if (wr_en_i)
      begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // read data holds until the next enabled read.
   always_ff @(posedge spy_clock)
   begin
      if (rd_en_i)
      begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

/* design/fm_capture.sv */
`timescale 1ns/10ps

module fm_capture #(
   parameter type payload_t = fm_spy_pkg::mon_narrow_t,
   parameter int  SPY_DEPTH = fm_spy_pkg::spy_depth_default
)(
   input  logic                         spy_clock,
   input  logic                         axi_reset,
   input  payload_t                     mon_i,
   input  logic                         freeze_i,
   output logic                         wr_en_o,
   output logic [$clog2(SPY_DEPTH)-1:0] wr_addr_o,
   output payload_t                     wr_data_o,
   output logic [$clog2(SPY_DEPTH)-1:0] wr_ptr_o,
   output logic                         wrapped_o
);

   localparam int                addr_w   = $clog2(SPY_DEPTH);
   localparam logic [addr_w-1:0] last_idx = addr_w'(SPY_DEPTH - 1);

   logic              take;
   logic [addr_w-1:0] cap_ptr;

   // circular increment.
   function automatic logic [addr_w-1:0] next_idx(input logic [addr_w-1:0] idx);
      return (idx == last_idx) ? '0 : idx + 1'b1;
   endfunction

   // frozen channels silently drop their words.
   assign take = mon_i.vld & ~freeze_i;

   always_ff @(posedge spy_clock)
   begin
      if (axi_reset)
      begin
         wr_en_o   <= 1'b0;
         cap_ptr   <= '0;
         wr_ptr_o  <= '0;
         wrapped_o <= 1'b0;
      end
      else
      begin
         wr_en_o <= take;
         if (take)
         begin
            cap_ptr <= next_idx(cap_ptr);
         end
         // visible pointer follows the memory write, one cycle behind capture.
         if (wr_en_o)
         begin
            wr_ptr_o <= next_idx(wr_addr_o);
            if (wr_addr_o == last_idx)
            begin
               wrapped_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge spy_clock)
   begin
      if (take)
      begin
         wr_addr_o <= cap_ptr;
         wr_data_o <= mon_i;
      end
   end

endmodule

/* design/fm_spy_pkg.sv */
package fm_spy_pkg;

   // apb bus widths.
   localparam int apb_dw = 32;
   localparam int apb_aw = 8;

   // default number of words per spy memory.
   localparam int spy_depth_default = 16;

   // monitor channel widths.
   localparam int narrow_dw = 16;
   localparam int wide_dw   = 32;

   typedef struct packed {
      logic [narrow_dw-1:0] data;
      logic                 vld;
   } mon_narrow_t;

   typedef struct packed {
      logic [wide_dw-1:0] data;
      logic               vld;
   } mon_wide_t;

   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [apb_aw-1:0] paddr;
      logic [apb_dw-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [apb_dw-1:0] prdata;
      logic              pready;
      logic              pslverr;
   } apb_rsp_t;

   // address region, taken from paddr[7:6].
   typedef enum logic [1:0] {
      ctrl  = 2'd0,
      data0 = 2'd1,
      data1 = 2'd2,
      meta  = 2'd3
   } region_e;

endpackage
